/* include/rename_defines.svh */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Structure sizes
`define ROB_DEPTH    16
`define DISP_WIDTH   2
`define COMMIT_WIDTH 2
`define WB_WIDTH     2
`define ARCH_REGS    16
`define PHYS_REGS    48

// Index widths
`define ROB_IDX_W    4
`define ARCH_W       4
`define PRF_W        6

`endif

/* verilog/rename_pkg.sv */
`include "rename_defines.svh"

package rename_pkg;

    typedef struct packed {
        logic               valid;
        logic               rd_wen;
        logic [`ARCH_W-1:0] rd_arch;
    } disp_req_t;

    typedef struct packed {
        logic                  alloc;
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic [`PRF_W-1:0]     new_prf;
    } disp_resp_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic                  exception;
        logic                  mispred;
    } wb_t;

    typedef struct packed {
        logic               valid;
        logic               rd_wen;
        logic [`ARCH_W-1:0] rd_arch;
        logic [`PRF_W-1:0]  new_prf;
        logic [`PRF_W-1:0]  old_prf;
    } commit_t;

    // One ROB slot
    typedef struct packed {
        logic               valid;
        logic               done;
        logic               rd_wen;
        logic [`ARCH_W-1:0] rd_arch;
        logic [`PRF_W-1:0]  new_prf;
        logic [`PRF_W-1:0]  old_prf;
        logic               exception;
        logic               mispred;
    } rob_entry_t;

    typedef enum logic {
        RETIRE_RUN,
        RETIRE_FLUSH
    } retire_state_e;

endpackage

/* verilog/free_list.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"

module free_list (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [`DISP_WIDTH-1:0]                    alloc_i,
    input  rename_pkg::disp_req_t [`DISP_WIDTH-1:0]   req_i,
    input  rename_pkg::commit_t [`COMMIT_WIDTH-1:0]   commit_i,
    input  logic                                      flush_i,
    output logic [`DISP_WIDTH-1:0]                    grant_o,
    output logic [`DISP_WIDTH-1:0][`PRF_W-1:0]        new_prf_o
);

    localparam int CNT_W = $clog2(`PHYS_REGS + 1);

    // One bit per physical register
    logic [`PHYS_REGS-1:0]               free_q;
    logic [`PHYS_REGS-1:0]               free_d;
    logic [`PHYS_REGS-1:0]               committed_q;
    logic [`PHYS_REGS-1:0]               committed_d;
    logic [`PHYS_REGS-1:0]               search_vec;
    logic [`DISP_WIDTH-1:0][`PRF_W-1:0]  pick;
    logic [CNT_W-1:0]                    free_cnt;
    logic [CNT_W-1:0]                    need_cnt;

    // Lowest free registers, one candidate per slot
    always_comb begin
        search_vec = free_q;
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            pick[s] = '0;
            for (int p = `PHYS_REGS - 1; p >= 0; p--) begin
                if (search_vec[p]) begin
                    pick[s] = p[`PRF_W-1:0];
                end
            end
            search_vec[pick[s]] = 1'b0;
        end
    end

    // Slots without a destination take no register
    always_comb begin
        free_cnt = CNT_W'($countones(free_q));
        need_cnt = '0;
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            grant_o[s]   = 1'b1;
            new_prf_o[s] = '0;
            if (req_i[s].valid && req_i[s].rd_wen) begin
                grant_o[s]   = (free_cnt > need_cnt);
                new_prf_o[s] = pick[need_cnt];
                need_cnt     = need_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        free_d      = free_q;
        committed_d = committed_q;
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            if (alloc_i[s] && req_i[s].rd_wen) begin
                free_d[new_prf_o[s]] = 1'b0;
            end
        end
        // Retired writer hands the arch value to its new register
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            if (commit_i[c].valid && commit_i[c].rd_wen) begin
                committed_d[commit_i[c].old_prf] = 1'b0;
                committed_d[commit_i[c].new_prf] = 1'b1;
                free_d[commit_i[c].old_prf]      = 1'b1;
            end
        end
        // Everything not holding committed state is free again
        if (flush_i) begin
            free_d = ~committed_d;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int p = 0; p < `PHYS_REGS; p++) begin
                free_q[p]      <= (p >= `ARCH_REGS);
                committed_q[p] <= (p < `ARCH_REGS);
            end
        end else begin
            free_q      <= free_d;
            committed_q <= committed_d;
        end
    end

endmodule

/* verilog/rename_map.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_map (
    input  logic                                      clk,
    input  logic                                      reset,
    input  rename_pkg::disp_req_t [`DISP_WIDTH-1:0]   req_i,
    input  logic [`DISP_WIDTH-1:0]                    alloc_i,
    input  logic [`DISP_WIDTH-1:0][`PRF_W-1:0]        new_prf_i,
    input  rename_pkg::commit_t [`COMMIT_WIDTH-1:0]   commit_i,
    input  logic                                      flush_i,
    output logic [`DISP_WIDTH-1:0][`PRF_W-1:0]        old_prf_o
);

    logic [`PRF_W-1:0] spec_q [`ARCH_REGS];
    logic [`PRF_W-1:0] arch_q [`ARCH_REGS];
    logic [`PRF_W-1:0] arch_d [`ARCH_REGS];

    // Previous mapping, nearest older slot in the group wins
    always_comb begin
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            old_prf_o[s] = '0;
            if (req_i[s].rd_wen) begin
                old_prf_o[s] = spec_q[req_i[s].rd_arch];
                for (int e = 0; e < s; e++) begin
                    if (req_i[e].valid && req_i[e].rd_wen &&
                        (req_i[e].rd_arch == req_i[s].rd_arch)) begin
                        old_prf_o[s] = new_prf_i[e];
                    end
                end
            end
        end
    end

    // Committed map with this cycle's retires folded in
    always_comb begin
        arch_d = arch_q;
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            if (commit_i[c].valid && commit_i[c].rd_wen) begin
                arch_d[commit_i[c].rd_arch] = commit_i[c].new_prf;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                spec_q[a] <= a[`PRF_W-1:0];
                arch_q[a] <= a[`PRF_W-1:0];
            end
        end else begin
            arch_q <= arch_d;
            if (flush_i) begin
                spec_q <= arch_d;
            end else begin
                // Later slot overwrites an earlier one to the same reg
                for (int s = 0; s < `DISP_WIDTH; s++) begin
                    if (alloc_i[s] && req_i[s].rd_wen) begin
                        spec_q[req_i[s].rd_arch] <= new_prf_i[s];
                    end
                end
            end
        end
    end

endmodule

/* verilog/rob.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"

module rob (
    input  logic                                      clk,
    input  logic                                      reset,
    input  rename_pkg::disp_req_t [`DISP_WIDTH-1:0]   req_i,
    input  logic [`DISP_WIDTH-1:0]                    grant_i,
    input  logic [`DISP_WIDTH-1:0][`PRF_W-1:0]        new_prf_i,
    input  logic [`DISP_WIDTH-1:0][`PRF_W-1:0]        old_prf_i,
    input  rename_pkg::wb_t [`WB_WIDTH-1:0]           wb_i,
    output logic [`DISP_WIDTH-1:0]                    alloc_o,
    output logic [`DISP_WIDTH-1:0][`ROB_IDX_W-1:0]    rob_idx_o,
    output logic                                      disp_ready_o,
    output rename_pkg::commit_t [`COMMIT_WIDTH-1:0]   commit_o,
    output logic                                      flush_o,
    output logic [`ROB_IDX_W-1:0]                     flush_rob_idx_o
);

    localparam int CNT_W = `ROB_IDX_W + 1;

    rename_pkg::rob_entry_t rob_q [`ROB_DEPTH];

    logic [`ROB_IDX_W-1:0]   head_q;
    logic [`ROB_IDX_W-1:0]   tail_q;
    logic [CNT_W-1:0]        count_q;
    rename_pkg::retire_state_e state_q;

    logic [CNT_W-1:0]                        n_alloc;
    logic [CNT_W-1:0]                        n_retire;
    logic                                    blocked;
    logic [`COMMIT_WIDTH-1:0]                retire_en;
    logic [`COMMIT_WIDTH-1:0][`ROB_IDX_W-1:0] retire_idx;
    logic                                    fault_hit;
    logic [`ROB_IDX_W-1:0]                   fault_idx;

    assign disp_ready_o = (count_q <= CNT_W'(`ROB_DEPTH - `DISP_WIDTH)) &&
                          (state_q == rename_pkg::RETIRE_RUN);

    // In-order allocation, a refused slot blocks all younger ones
    always_comb begin
        n_alloc = '0;
        blocked = (state_q == rename_pkg::RETIRE_FLUSH);
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            alloc_o[s]   = 1'b0;
            rob_idx_o[s] = tail_q + n_alloc[`ROB_IDX_W-1:0];
            if (req_i[s].valid) begin
                if (!blocked && grant_i[s] &&
                    ((count_q + n_alloc) < CNT_W'(`ROB_DEPTH))) begin
                    alloc_o[s] = 1'b1;
                    n_alloc    = n_alloc + 1'b1;
                end else begin
                    blocked = 1'b1;
                end
            end
        end
    end

    // Retire chain from the head, stops after a faulting entry
    always_comb begin
        n_retire  = '0;
        fault_hit = 1'b0;
        fault_idx = head_q;
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            retire_idx[c] = head_q + c[`ROB_IDX_W-1:0];
            retire_en[c]  = 1'b0;
            if ((state_q == rename_pkg::RETIRE_RUN) && !fault_hit &&
                (n_retire == CNT_W'(c)) &&
                rob_q[retire_idx[c]].valid && rob_q[retire_idx[c]].done) begin
                retire_en[c] = 1'b1;
                n_retire     = n_retire + 1'b1;
                if (rob_q[retire_idx[c]].exception || rob_q[retire_idx[c]].mispred) begin
                    fault_hit = 1'b1;
                    fault_idx = retire_idx[c];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_q          <= '0;
            tail_q          <= '0;
            count_q         <= '0;
            state_q         <= rename_pkg::RETIRE_RUN;
            commit_o        <= '0;
            flush_o         <= 1'b0;
            flush_rob_idx_o <= '0;
            for (int e = 0; e < `ROB_DEPTH; e++) begin
                rob_q[e].valid <= 1'b0;
                rob_q[e].done  <= 1'b0;
            end
        end else begin
            // Completions arrive in any order
            for (int w = 0; w < `WB_WIDTH; w++) begin
                if (wb_i[w].valid) begin
                    rob_q[wb_i[w].rob_idx].done      <= 1'b1;
                    rob_q[wb_i[w].rob_idx].exception <= wb_i[w].exception;
                    rob_q[wb_i[w].rob_idx].mispred   <= wb_i[w].mispred;
                end
            end

            for (int s = 0; s < `DISP_WIDTH; s++) begin
                if (alloc_o[s]) begin
                    rob_q[rob_idx_o[s]].valid     <= 1'b1;
                    rob_q[rob_idx_o[s]].done      <= 1'b0;
                    rob_q[rob_idx_o[s]].rd_wen    <= req_i[s].rd_wen;
                    rob_q[rob_idx_o[s]].rd_arch   <= req_i[s].rd_arch;
                    rob_q[rob_idx_o[s]].new_prf   <= new_prf_i[s];
                    rob_q[rob_idx_o[s]].old_prf   <= old_prf_i[s];
                    rob_q[rob_idx_o[s]].exception <= 1'b0;
                    rob_q[rob_idx_o[s]].mispred   <= 1'b0;
                end
            end

            for (int c = 0; c < `COMMIT_WIDTH; c++) begin
                commit_o[c].valid   <= retire_en[c];
                commit_o[c].rd_wen  <= rob_q[retire_idx[c]].rd_wen;
                commit_o[c].rd_arch <= rob_q[retire_idx[c]].rd_arch;
                commit_o[c].new_prf <= rob_q[retire_idx[c]].new_prf;
                commit_o[c].old_prf <= rob_q[retire_idx[c]].old_prf;
                if (retire_en[c]) begin
                    rob_q[retire_idx[c]].valid <= 1'b0;
                end
            end

            flush_o <= fault_hit;
            if (fault_hit) begin
                flush_rob_idx_o <= fault_idx;
            end

            // Flush cycle drops every younger entry
            if (state_q == rename_pkg::RETIRE_FLUSH) begin
                head_q  <= '0;
                tail_q  <= '0;
                count_q <= '0;
                state_q <= rename_pkg::RETIRE_RUN;
                for (int e = 0; e < `ROB_DEPTH; e++) begin
                    rob_q[e].valid <= 1'b0;
                end
            end else begin
                head_q  <= head_q + n_retire[`ROB_IDX_W-1:0];
                tail_q  <= tail_q + n_alloc[`ROB_IDX_W-1:0];
                count_q <= count_q + n_alloc - n_retire;
                if (fault_hit) begin
                    state_q <= rename_pkg::RETIRE_FLUSH;
                end
            end
        end
    end

endmodule

/* verilog/rename_commit_top.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_commit_top (
    input  logic                                      clk,
    input  logic                                      reset,
    input  rename_pkg::disp_req_t [`DISP_WIDTH-1:0]   disp_req_i,
    input  rename_pkg::wb_t [`WB_WIDTH-1:0]           wb_i,
    output rename_pkg::disp_resp_t [`DISP_WIDTH-1:0]  disp_resp_o,
    output logic                                      disp_ready_o,
    output rename_pkg::commit_t [`COMMIT_WIDTH-1:0]   commit_o,
    output logic                                      flush_o,
    output logic [`ROB_IDX_W-1:0]                     flush_rob_idx_o
);

    logic [`DISP_WIDTH-1:0]                  grant;
    logic [`DISP_WIDTH-1:0]                  alloc;
    logic [`DISP_WIDTH-1:0][`PRF_W-1:0]      new_prf;
    logic [`DISP_WIDTH-1:0][`PRF_W-1:0]      old_prf;
    logic [`DISP_WIDTH-1:0][`ROB_IDX_W-1:0]  rob_idx;

    free_list free_list_inst (
        .clk       (clk),
        .reset     (reset),
        .alloc_i   (alloc),
        .req_i     (disp_req_i),
        .commit_i  (commit_o),
        .flush_i   (flush_o),
        .grant_o   (grant),
        .new_prf_o (new_prf)
    );

    rename_map rename_map_inst (
        .clk       (clk),
        .reset     (reset),
        .req_i     (disp_req_i),
        .alloc_i   (alloc),
        .new_prf_i (new_prf),
        .commit_i  (commit_o),
        .flush_i   (flush_o),
        .old_prf_o (old_prf)
    );

    rob rob_inst (
        .clk             (clk),
        .reset           (reset),
        .req_i           (disp_req_i),
        .grant_i         (grant),
        .new_prf_i       (new_prf),
        .old_prf_i       (old_prf),
        .wb_i            (wb_i),
        .alloc_o         (alloc),
        .rob_idx_o       (rob_idx),
        .disp_ready_o    (disp_ready_o),
        .commit_o        (commit_o),
        .flush_o         (flush_o),
        .flush_rob_idx_o (flush_rob_idx_o)
    );

    // Per-slot rename result
    always_comb begin
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            disp_resp_o[s].alloc   = alloc[s];
            disp_resp_o[s].rob_idx = rob_idx[s];
            disp_resp_o[s].new_prf = new_prf[s];
        end
    end

endmodule

/* verification/rename_commit_tb.sv */
`timescale 1ns/10ps
`include "rename_defines.svh"

module rename_commit_tb;

    localparam int CYCLE_LIMIT = 3000;

    logic clk;
    logic reset;
    rename_pkg::disp_req_t [`DISP_WIDTH-1:0]  disp_req;
    rename_pkg::wb_t [`WB_WIDTH-1:0]          wb;
    rename_pkg::disp_resp_t [`DISP_WIDTH-1:0] disp_resp;
    logic                                     disp_ready;
    rename_pkg::commit_t [`COMMIT_WIDTH-1:0]  commit;
    logic                                     flush;
    logic [`ROB_IDX_W-1:0]                    flush_idx;

    // Reference model state
    logic [`PRF_W-1:0]     spec_map [`ARCH_REGS];
    logic [`PRF_W-1:0]     arch_map [`ARCH_REGS];
    logic [`PHYS_REGS-1:0] busy;
    logic [`PHYS_REGS-1:0] arch_set;
    logic [`PHYS_REGS-1:0] used_prf;
    logic [`ROB_IDX_W-1:0] tail_exp;
    logic [`ROB_IDX_W-1:0] q_idx [$];
    logic                  q_wen [$];
    logic [`ARCH_W-1:0]    q_arch [$];
    logic [`PRF_W-1:0]     q_new [$];
    logic [`PRF_W-1:0]     q_old [$];
    logic                  q_fault [$];
    logic                  q_wb [$];
    logic [`DISP_WIDTH-1:0] alloc_seen;
    rename_pkg::commit_t   commit_log [$];

    int errors;
    int checks;
    int cycles;
    int flush_cnt;
    int seed;
    int wb_rate;
    int test_start;
    int saved;
    bit auto_wb;

    rename_commit_top rename_commit_top_inst (
        .clk             (clk),
        .reset           (reset),
        .disp_req_i      (disp_req),
        .wb_i            (wb),
        .disp_resp_o     (disp_resp),
        .disp_ready_o    (disp_ready),
        .commit_o        (commit),
        .flush_o         (flush),
        .flush_rob_idx_o (flush_idx)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task compare_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task report_error(input string msg);
        $display("Error: %s", msg);
        errors++;
    endtask

    function int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task pop_head;
        void'(q_idx.pop_front());
        void'(q_wen.pop_front());
        void'(q_arch.pop_front());
        void'(q_new.pop_front());
        void'(q_old.pop_front());
        void'(q_fault.pop_front());
        void'(q_wb.pop_front());
    endtask

    // Commits against the model head, then new allocations
    always @(negedge clk) begin : monitor
        logic                  faulted;
        logic [`ROB_IDX_W-1:0] fault_idx;
        logic [`ARCH_W-1:0]    a;
        if (!reset) begin
            faulted = 1'b0;
            fault_idx = '0;
            for (int c = 0; c < `COMMIT_WIDTH; c++) begin
                if (commit[c].valid) begin
                    assert (q_idx.size() > 0 && !faulted)
                        else report_error($sformatf("unexpected commit in slot %0d", c));
                    if (q_idx.size() > 0 && !faulted) begin
                        compare_field("commit.rd_wen", commit[c].rd_wen, q_wen[0]);
                        compare_field("commit.rd_arch", commit[c].rd_arch, q_arch[0]);
                        compare_field("commit.new_prf", commit[c].new_prf, q_new[0]);
                        compare_field("commit.old_prf", commit[c].old_prf, q_old[0]);
                        commit_log.push_back(commit[c]);
                        if (q_wen[0]) begin
                            arch_map[q_arch[0]] = q_new[0];
                            arch_set[q_old[0]] = 1'b0;
                            arch_set[q_new[0]] = 1'b1;
                            busy[q_old[0]] = 1'b0;
                        end
                        faulted = q_fault[0];
                        fault_idx = q_idx[0];
                        pop_head();
                    end
                end
            end
            compare_field("flush_o", flush, faulted);
            if (flush && faulted) begin
                compare_field("flush_rob_idx_o", flush_idx, fault_idx);
                flush_cnt++;
                while (q_idx.size() > 0) pop_head();
                spec_map = arch_map;
                busy = arch_set;
                tail_exp = '0;
            end
            alloc_seen = '0;
            for (int s = 0; s < `DISP_WIDTH; s++) begin
                if (disp_resp[s].alloc) begin
                    alloc_seen[s] = 1'b1;
                    a = disp_req[s].rd_arch;
                    compare_field("disp_resp.rob_idx", disp_resp[s].rob_idx, tail_exp);
                    q_idx.push_back(tail_exp);
                    tail_exp = tail_exp + 1'b1;
                    q_wen.push_back(disp_req[s].rd_wen);
                    q_arch.push_back(a);
                    q_fault.push_back(1'b0);
                    q_wb.push_back(1'b0);
                    if (disp_req[s].rd_wen) begin
                        assert (!busy[disp_resp[s].new_prf]) else report_error($sformatf(
                            "register %0d handed out while in use", disp_resp[s].new_prf));
                        q_new.push_back(disp_resp[s].new_prf);
                        q_old.push_back(spec_map[a]);
                        spec_map[a] = disp_resp[s].new_prf;
                        busy[disp_resp[s].new_prf] = 1'b1;
                        used_prf[disp_resp[s].new_prf] = 1'b1;
                    end else begin
                        q_new.push_back('0);
                        q_old.push_back('0);
                    end
                end
            end
        end
    end

    // One completion per cycle, picked at random among pending entries
    task automatic wb_step;
        int cand [$];
        int pick;
        int port;
        logic ex;
        logic mp;
        for (int i = 0; i < q_idx.size(); i++) begin
            if (!q_wb[i]) cand.push_back(i);
        end
        if (cand.size() > 0) begin
            pick = cand[rand_below(cand.size())];
            q_wb[pick] = 1'b1;
            if (wb_rate > 0 && rand_below(wb_rate) == 0) q_fault[pick] = 1'b1;
            mp = q_fault[pick] && rand_below(2) == 0;
            ex = q_fault[pick] && !mp;
            port = rand_below(`WB_WIDTH);
            wb <= '0;
            wb[port] <= '{valid: 1'b1, rob_idx: q_idx[pick], exception: ex, mispred: mp};
        end else begin
            wb <= '0;
        end
    endtask

    task cycle_step;
        @(posedge clk);
        if (auto_wb) wb_step();
        else wb <= '0;
    endtask

    // Holds the pair until both slots are allocated
    task dispatch_pair(input bit w0, input int a0, input bit v1, input bit w1, input int a1);
        rename_pkg::disp_req_t r0;
        rename_pkg::disp_req_t r1;
        r0 = '{valid: 1'b1, rd_wen: w0, rd_arch: a0[`ARCH_W-1:0]};
        r1 = '{valid: v1, rd_wen: w1, rd_arch: a1[`ARCH_W-1:0]};
        cycle_step();
        disp_req[0] <= r0;
        disp_req[1] <= r1;
        while (r0.valid || r1.valid) begin
            cycle_step();
            if (alloc_seen[0]) begin
                r0 = alloc_seen[1] ? '0 : r1;
                r1 = '0;
            end
            disp_req[0] <= r0;
            disp_req[1] <= r1;
        end
    endtask

    task drain;
        auto_wb = 1'b1;
        while (q_idx.size() > 0) cycle_step();
        auto_wb = 1'b0;
        repeat (3) cycle_step();
    endtask

    task finish_test(input string name);
        $display("Test %s: %s (%0d errors)", name,
                 (errors == test_start) ? "ok" : "failed", errors - test_start);
        test_start = errors;
    endtask

    initial begin
        seed = 44978;
        reset = 1'b1;
        disp_req = '0;
        wb = '0;
        auto_wb = 1'b0;
        tail_exp = '0;
        used_prf = '0;
        for (int a = 0; a < `ARCH_REGS; a++) begin
            spec_map[a] = a[`PRF_W-1:0];
            arch_map[a] = a[`PRF_W-1:0];
        end
        for (int p = 0; p < `PHYS_REGS; p++) begin
            arch_set[p] = (p < `ARCH_REGS);
        end
        busy = arch_set;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        #1;
        compare_field("commit[0].valid", commit[0].valid, 0);
        compare_field("commit[1].valid", commit[1].valid, 0);
        compare_field("flush_o", flush, 0);
        compare_field("disp_ready_o", disp_ready, 1);
        commit_log.delete();
        dispatch_pair(1, 1, 1, 1, 2);
        drain();
        if (commit_log.size() < 2) begin
            report_error("first two renames did not commit");
        end else begin
            compare_field("commit.old_prf r1", commit_log[0].old_prf, 1);
            compare_field("commit.old_prf r2", commit_log[1].old_prf, 2);
        end
        finish_test("reset_state");

        dispatch_pair(1, 5, 1, 1, 5);
        repeat (3) dispatch_pair(1, rand_below(16), 1, 1, rand_below(16));
        drain();
        finish_test("in_order_retire");

        repeat (8) dispatch_pair(1, rand_below(16), 1, 1, rand_below(16));
        cycle_step();
        disp_req[0] <= '{valid: 1'b1, rd_wen: 1'b1, rd_arch: 4'd3};
        repeat (4) begin
            cycle_step();
            @(negedge clk);
            #1;
            assert (!disp_ready && alloc_seen == '0)
                else report_error("dispatch accepted while ROB full");
        end
        cycle_step();
        wb[0] <= '{valid: 1'b1, rob_idx: q_idx[0], exception: 1'b0, mispred: 1'b0};
        q_wb[0] = 1'b1;
        while (!alloc_seen[0]) cycle_step();
        disp_req[0] <= '0;
        drain();
        compare_field("held rd_arch", commit_log[commit_log.size() - 1].rd_arch, 3);
        finish_test("back_pressure");

        repeat (3) dispatch_pair(1, rand_below(16), 1, 1, rand_below(16));
        q_fault[2] = 1'b1;
        saved = q_arch[2];
        flush_cnt = 0;
        drain();
        compare_field("flush count", flush_cnt, 1);
        dispatch_pair(1, saved, 0, 0, 0);
        drain();
        finish_test("flush");

        wb_rate = 24;
        auto_wb = 1'b1;
        repeat (100) begin
            dispatch_pair(rand_below(8) != 0, rand_below(16), 1, rand_below(8) != 0,
                          rand_below(16));
        end
        drain();
        wb_rate = 0;
        used_prf = '0;
        repeat (2) begin
            for (int a = 0; a < `ARCH_REGS; a += 2) begin
                dispatch_pair(1, a, 1, 1, a + 1);
            end
            drain();
        end
        compare_field("distinct registers", $countones(used_prf), `PHYS_REGS - `ARCH_REGS);
        finish_test("register_reuse");

        // Lowest free register once the ROB is empty
        saved = -1;
        for (int p = 0; p < `PHYS_REGS; p++) begin
            if (!busy[p] && saved < 0) begin
                saved = p;
            end
        end
        dispatch_pair(0, 5, 1, 0, 6);
        dispatch_pair(0, 7, 1, 0, 7);
        dispatch_pair(1, 8, 0, 0, 0);
        compare_field("new_prf after no-destination", q_new[q_new.size() - 1], saved);
        drain();
        finish_test("no_destination");

        $display("Checks %0d, errors %0d, flushes in last test group %0d",
                 checks, errors, flush_cnt);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+include
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/rename_map.sv
verilog/rob.sv
verilog/rename_commit_top.sv
verification/rename_commit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the rename/commit testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module rename_commit_tb -o rename_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rename_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "Pass message not found"
exit 1
